// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bus_filter
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: include/bus_filter_params.svh
`ifndef BUS_FILTER_PARAMS_SVH
`define BUS_FILTER_PARAMS_SVH

// ========================================
// bit timing
// ========================================

// enc_clk cycles per 1553 bit
`define SAMPLES_PER_BIT 8
// enc_clk cycles per half-bit
`define HALF_BIT 4

// ========================================
// word format
// ========================================

// payload bits per word
`define WORD_BITS 16
// bit times per word: 3 sync, 16 data, 1 parity
`define FRAME_BITS 20
// each sync level lasts three half-bits
`define SYNC_HALF_BITS 3

// ========================================
// filter address
// ========================================

`define FILTER_RT 5'h0A
`define FILTER_SUB 5'h01
// word count field of zero stands for this
`define MAX_DATA_WORDS 32

`endif

// File: rtl/bus_filter_top.sv
`default_nettype none

module bus_filter_top (
   input  logic enc_clk,
   input  logic reset_slow,
   input  logic rx_p,
   input  logic rx_n,
   input  logic bypass,
   output logic tx_p,
   output logic tx_n,
   output logic tx_busy,
   output logic tx_dval,
   output logic csw,
   output logic dw,
   output logic perr
);

   // decoded words from the line
   word_if rx_bus ();
   // words cleared for transmit
   word_if fwd_bus ();

   logic rx_sync_p;
   logic rx_sync_n;
   logic good_word;

   manchester_decoder u_decoder (
      .enc_clk    (enc_clk),
      .reset_slow (reset_slow),
      .rx_p       (rx_p),
      .rx_n       (rx_n),
      .rx_sync_p  (rx_sync_p),
      .rx_sync_n  (rx_sync_n),
      .rx_bus     (rx_bus.source)
   );

   command_filter u_filter (
      .enc_clk    (enc_clk),
      .reset_slow (reset_slow),
      .rx_bus     (rx_bus.sink),
      .fwd_bus    (fwd_bus.source)
   );

   manchester_encoder u_encoder (
      .enc_clk    (enc_clk),
      .reset_slow (reset_slow),
      .fwd_bus    (fwd_bus.sink),
      .bypass     (bypass),
      .rx_sync_p  (rx_sync_p),
      .rx_sync_n  (rx_sync_n),
      .tx_p       (tx_p),
      .tx_n       (tx_n),
      .tx_busy    (tx_busy),
      .tx_dval    (tx_dval)
   );

   // capture strobes, every received word regardless of filter
   assign good_word = rx_bus.valid && !rx_bus.perr;
   assign csw       = good_word && (rx_bus.kind == mil1553_pkg::KIND_COMMAND);
   assign dw        = good_word && (rx_bus.kind == mil1553_pkg::KIND_DATA);
   // bad parity replaces csw or dw
   assign perr      = rx_bus.valid && rx_bus.perr;

endmodule

`default_nettype wire

// File: rtl/command_filter.sv
`default_nettype none

`include "bus_filter_params.svh"

module command_filter (
   input  logic   enc_clk,
   input  logic   reset_slow,
   word_if.sink   rx_bus,
   word_if.source fwd_bus
);

   logic       good_cmd;
   logic       good_data;
   logic       addr_match;
   logic       pass_word;
   logic       fwd_active;
   // data words still owed to the current message
   logic [5:0] remaining;
   logic [5:0] load_count;

   // ========================================
   // word classification
   // ========================================

   // bad parity words are invisible here
   assign good_cmd  = rx_bus.valid && !rx_bus.perr &&
                      (rx_bus.kind == mil1553_pkg::KIND_COMMAND);
   assign good_data = rx_bus.valid && !rx_bus.perr &&
                      (rx_bus.kind == mil1553_pkg::KIND_DATA);

   // fixed rt and subaddress, direction not checked
   assign addr_match = (rx_bus.word.cmd.rt_address == `FILTER_RT) &&
                       (rx_bus.word.cmd.sub_address == `FILTER_SUB);

   // zero count field means a full 32-word message
   assign load_count = (rx_bus.word.cmd.dwcnt_mcode == 5'd0) ?
                       6'(`MAX_DATA_WORDS) : {1'b0, rx_bus.word.cmd.dwcnt_mcode};

   // matching command, or a data word of an open message
   assign pass_word = (good_cmd && addr_match) || (good_data && fwd_active);

   // ========================================
   // forwarding state
   // ========================================

   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         fwd_active    <= 1'b0;
         remaining     <= 6'd0;
         fwd_bus.valid <= 1'b0;
      end else begin
         // one cycle behind rx_bus.valid
         fwd_bus.valid <= pass_word;
         if (good_cmd) begin
            // any command opens or closes the window
            fwd_active <= addr_match;
            if (addr_match) begin
               remaining <= load_count;
            end
         end else if (good_data && fwd_active) begin
            remaining <= remaining - 6'd1;
            // last owed word closes it
            if (remaining == 6'd1) begin
               fwd_active <= 1'b0;
            end
         end
      end
   end

   // payload follows the strobe
   always_ff @(posedge enc_clk) begin
      if (pass_word) begin
         fwd_bus.word <= rx_bus.word;
         fwd_bus.kind <= rx_bus.kind;
         fwd_bus.perr <= rx_bus.perr;
      end
   end

endmodule

`default_nettype wire

// File: rtl/manchester_decoder.sv
`default_nettype none

`include "bus_filter_params.svh"

module manchester_decoder (
   input  logic   enc_clk,
   input  logic   reset_slow,
   input  logic   rx_p,
   input  logic   rx_n,
   output logic   rx_sync_p,
   output logic   rx_sync_n,
   word_if.source rx_bus
);

   // one sync level in clocks
   localparam int SYNC_CLKS    = `SYNC_HALF_BITS * `HALF_BIT;
   // accepted run of the first sync level, the upper bound
   // covers a parity half-bit merged into it
   localparam int RUN_MIN      = SYNC_CLKS - 2;
   localparam int RUN_MAX      = SYNC_CLKS + `HALF_BIT + 2;
   // mid point of the first half of data bit 0, from the sync edge
   localparam int FIRST_SAMPLE = SYNC_CLKS + `HALF_BIT / 2;

   typedef enum logic [1:0] {
      ST_HUNT,
      ST_SYNC2,
      ST_BITS
   } dec_state_e;

   logic [1:0]              sync_p;
   logic [1:0]              sync_n;
   logic [1:0]              sym;
   logic [1:0]              sym_q;
   logic [4:0]              run_len;
   logic                    sym_edge;
   logic                    sync_edge;
   dec_state_e              state;
   logic [7:0]              tick;
   logic [7:0]              next_sample;
   logic [4:0]              bit_cnt;
   logic [`WORD_BITS-1:0]   shreg;
   mil1553_pkg::word_kind_e kind_q;
   logic                    sample_now;
   logic                    bit_ok;
   logic                    last_bit;

   // ========================================
   // input synchronizer
   // ========================================

   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         sync_p <= 2'b00;
         sync_n <= 2'b00;
      end else begin
         sync_p <= {sync_p[0], rx_p};
         sync_n <= {sync_n[0], rx_n};
      end
   end

   // also feeds the bypass path
   assign rx_sync_p = sync_p[1];
   assign rx_sync_n = sync_n[1];

   // symbol: {line active, level}
   // both low means idle, so idle never counts as a level
   assign sym      = {rx_sync_p ^ rx_sync_n, rx_sync_p};
   assign sym_edge = (sym != sym_q);

   // ========================================
   // sync hunt
   // ========================================

   // run length of sym_q, saturating
   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         sym_q   <= 2'b00;
         run_len <= 5'd0;
      end else begin
         sym_q <= sym;
         if (sym_edge) begin
            run_len <= 5'd1;
         end else if (run_len != '1) begin
            run_len <= run_len + 5'd1;
         end
      end
   end

   // long active level flipping to the opposite active level
   // normal manchester never holds a level past two half-bits
   assign sync_edge = sym_edge && sym[1] && sym_q[1] &&
                      (run_len >= 5'(RUN_MIN)) && (run_len <= 5'(RUN_MAX));

   assign sample_now = (state == ST_BITS) && (tick == next_sample);
   assign bit_ok     = sample_now && sym[1];
   // parity is the sample after the 16 data bits
   assign last_bit   = (bit_cnt == 5'(`WORD_BITS));

   // ========================================
   // word FSM
   // ========================================

   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         state        <= ST_HUNT;
         tick         <= 8'd0;
         next_sample  <= 8'd0;
         bit_cnt      <= 5'd0;
         rx_bus.valid <= 1'b0;
      end else begin
         rx_bus.valid <= 1'b0;
         tick         <= tick + 8'd1;
         case (state)
            ST_HUNT: begin
               if (sync_edge) begin
                  // tick counts clocks since the sync edge
                  state       <= ST_SYNC2;
                  tick        <= 8'd1;
                  next_sample <= 8'(FIRST_SAMPLE);
                  bit_cnt     <= 5'd0;
               end
            end
            ST_SYNC2: begin
               // second level must hold too, else it was noise
               if (sym_edge) begin
                  state <= ST_HUNT;
               end else if (tick == 8'(RUN_MIN)) begin
                  state <= ST_BITS;
               end
            end
            ST_BITS: begin
               if (sample_now && !sym[1]) begin
                  // line dropped to idle mid word
                  state <= ST_HUNT;
               end else if (bit_ok) begin
                  next_sample <= next_sample + 8'(`SAMPLES_PER_BIT);
                  bit_cnt     <= bit_cnt + 5'd1;
                  if (last_bit) begin
                     state        <= ST_HUNT;
                     rx_bus.valid <= 1'b1;
                  end
               end
            end
            default: state <= ST_HUNT;
         endcase
      end
   end

   // payload path
   always_ff @(posedge enc_clk) begin
      if ((state == ST_HUNT) && sync_edge) begin
         // first level tells the kind
         kind_q <= sym_q[0] ? mil1553_pkg::KIND_COMMAND : mil1553_pkg::KIND_DATA;
      end
      if (bit_ok) begin
         if (last_bit) begin
            rx_bus.word.raw <= shreg;
            rx_bus.kind     <= kind_q;
            // odd parity over data and parity bit
            rx_bus.perr     <= ~(^{shreg, sym[0]});
         end else begin
            // first half-bit level is the bit value, msb first
            shreg <= {shreg[`WORD_BITS-2:0], sym[0]};
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/manchester_encoder.sv
`default_nettype none

`include "bus_filter_params.svh"

module manchester_encoder (
   input  logic enc_clk,
   input  logic reset_slow,
   word_if.sink fwd_bus,
   input  logic bypass,
   input  logic rx_sync_p,
   input  logic rx_sync_n,
   output logic tx_p,
   output logic tx_n,
   output logic tx_busy,
   output logic tx_dval
);

   // whole frame as half-bit levels, msb goes out first
   localparam int HALF_BITS = 2 * `FRAME_BITS;
   localparam int WORD_CLKS = `FRAME_BITS * `SAMPLES_PER_BIT;
   localparam int SYNC_LEN  = 2 * `SYNC_HALF_BITS;

   logic [7:0]           cyc;
   logic [1:0]           half_cnt;
   logic [HALF_BITS-1:0] pattern;
   logic                 last_cyc;
   logic                 load;
   logic                 enc_p;
   logic                 enc_n;

   // ========================================
   // frame builder
   // ========================================

   function automatic logic [HALF_BITS-1:0] build_frame(
      input mil1553_pkg::bus_word_u  w,
      input mil1553_pkg::word_kind_e k
   );
      logic [HALF_BITS-1:0] pat;
      logic                 par;
      int                   i;
      // odd parity over data plus parity bit
      par = ~(^w.raw);
      pat = '0;
      // sync, three half-bits per level
      if (k == mil1553_pkg::KIND_COMMAND) begin
         pat[HALF_BITS-1 -: SYNC_LEN] = {{`SYNC_HALF_BITS{1'b1}}, {`SYNC_HALF_BITS{1'b0}}};
      end else begin
         pat[HALF_BITS-1 -: SYNC_LEN] = {{`SYNC_HALF_BITS{1'b0}}, {`SYNC_HALF_BITS{1'b1}}};
      end
      // one is high-then-low, zero is low-then-high
      for (i = 0; i < `WORD_BITS; i++) begin
         pat[HALF_BITS-1-SYNC_LEN-2*i] = w.raw[`WORD_BITS-1-i];
         pat[HALF_BITS-2-SYNC_LEN-2*i] = ~w.raw[`WORD_BITS-1-i];
      end
      pat[1] = par;
      pat[0] = ~par;
      return pat;
   endfunction

   // ========================================
   // serializer
   // ========================================

   assign last_cyc = tx_busy && (cyc == 8'(WORD_CLKS - 1));
   // a word landing on the final cycle chains straight on,
   // otherwise anything during busy is lost
   assign load     = fwd_bus.valid && (!tx_busy || last_cyc);

   always_ff @(posedge enc_clk or posedge reset_slow) begin
      if (reset_slow) begin
         tx_busy  <= 1'b0;
         cyc      <= 8'd0;
         half_cnt <= 2'd0;
      end else if (load) begin
         tx_busy  <= 1'b1;
         cyc      <= 8'd0;
         half_cnt <= 2'd0;
      end else if (tx_busy) begin
         cyc      <= cyc + 8'd1;
         // wraps once per half-bit
         half_cnt <= half_cnt + 2'd1;
         if (last_cyc) begin
            tx_busy <= 1'b0;
         end
      end
   end

   // shift register of line levels
   always_ff @(posedge enc_clk) begin
      if (load) begin
         pattern <= build_frame(fwd_bus.word, fwd_bus.kind);
      end else if (tx_busy && (half_cnt == 2'(`HALF_BIT - 1))) begin
         pattern <= {pattern[HALF_BITS-2:0], 1'b0};
      end
   end

   // ========================================
   // line drivers
   // ========================================

   // both lines low while idle
   assign enc_p = tx_busy && pattern[HALF_BITS-1];
   assign enc_n = tx_busy && !pattern[HALF_BITS-1];

   // bypass hands the line to the synchronized rx pair
   assign tx_p = bypass ? rx_sync_p : enc_p;
   assign tx_n = bypass ? rx_sync_n : enc_n;

   // last line cycle of the word
   assign tx_dval = last_cyc;

endmodule

`default_nettype wire

// File: rtl/mil1553_pkg.sv
`default_nettype none

`include "bus_filter_params.svh"

package mil1553_pkg;

   // one 16-bit bus word, seen as raw data
   // or as the fields of a command word
   typedef union packed {
      logic [`WORD_BITS-1:0] raw;
      struct packed {
         // remote terminal address, msb first on the line
         logic [4:0] rt_address;
         // transmit/receive direction
         logic       tr;
         logic [4:0] sub_address;
         // word count, or mode code when subaddress is 0 or 31
         logic [4:0] dwcnt_mcode;
      } cmd;
   } bus_word_u;

   // word kind follows the sync shape
   // high-then-low sync marks a command or status word
   // low-then-high sync marks a data word
   typedef enum logic {
      KIND_DATA    = 1'b0,
      KIND_COMMAND = 1'b1
   } word_kind_e;

endpackage

`default_nettype wire

// File: rtl/word_if.sv
`default_nettype none

// one decoded bus word plus its qualifiers
// valid is a single-cycle strobe, the rest is stable with it
interface word_if;

   mil1553_pkg::bus_word_u  word;
   mil1553_pkg::word_kind_e kind;
   logic                    valid;
   // parity failed, only meaningful with valid
   logic                    perr;

   modport source (
      output word,
      output kind,
      output valid,
      output perr
   );

   modport sink (
      input word,
      input kind,
      input valid,
      input perr
   );

endinterface

`default_nettype wire

// File: sim/tb_bus_filter.sv
`default_nettype none

`include "bus_filter_params.svh"

module tb_bus_filter;
   timeunit 1ns;
   timeprecision 100ps;

   // size of one word on the line in clocks and in half-bits
   localparam int WORD_CLKS  = `FRAME_BITS * `SAMPLES_PER_BIT;
   localparam int HALF_BITS  = 2 * `FRAME_BITS;
   localparam int WAIT_LIMIT = 4000;
   // idle line between messages
   localparam int IDLE_GAP   = 24;

   logic enc_clk;
   logic reset_slow;
   logic rx_p;
   logic rx_n;
   logic bypass;
   logic tx_p;
   logic tx_n;
   logic tx_busy;
   logic tx_dval;
   logic csw;
   logic dw;
   logic perr;

   // expected and observed tx words
   logic [15:0]             exp_words [$];
   mil1553_pkg::word_kind_e exp_kinds [$];
   logic [15:0]             got_words [$];
   mil1553_pkg::word_kind_e got_kinds [$];

   int   error_count;
   int   timeout_count;
   logic timed_out;
   // pulse counters cleared per test
   int   csw_count;
   int   dw_count;
   int   perr_count;
   int   dval_count;
   int   busy_count;

   // line monitor state
   logic halves [0:HALF_BITS-1];
   int   mon_cyc;
   logic mon_active;
   logic busy_q;
   logic dval_q;
   // rx history for the bypass check
   logic rx_p_d1;
   logic rx_p_d2;
   logic rx_n_d1;
   logic rx_n_d2;
   logic bypass_chk;

   tb_clock_gen #(
      .PERIOD_NS    (8),
      .RESET_CYCLES (16)
   ) u_clock_gen (
      .enc_clk    (enc_clk),
      .reset_slow (reset_slow)
   );

   bus_filter_top u_bus_filter_top (
      .enc_clk    (enc_clk),
      .reset_slow (reset_slow),
      .rx_p       (rx_p),
      .rx_n       (rx_n),
      .bypass     (bypass),
      .tx_p       (tx_p),
      .tx_n       (tx_n),
      .tx_busy    (tx_busy),
      .tx_dval    (tx_dval),
      .csw        (csw),
      .dw         (dw),
      .perr       (perr)
   );

   // ========================================
   // helpers
   // ========================================

   task automatic log_error(input string msg);
      error_count++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic report_timeout(input string what);
      timeout_count++;
      timed_out = 1'b1;
      $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
   endtask

   function automatic logic outputs_low();
      return !(tx_p | tx_n | tx_busy | tx_dval | csw | dw | perr);
   endfunction

   // receive direction with tr low
   function automatic logic [15:0] command_word(input logic [4:0] rt,
                                                input logic [4:0] sub,
                                                input logic [4:0] count);
      return {rt, 1'b0, sub, count};
   endfunction

   task automatic expect_word(input logic [15:0] w, input mil1553_pkg::word_kind_e k);
      exp_words.push_back(w);
      exp_kinds.push_back(k);
   endtask

   task automatic clear_counts();
      exp_words.delete();
      exp_kinds.delete();
      got_words.delete();
      got_kinds.delete();
      csw_count  = 0;
      dw_count   = 0;
      perr_count = 0;
      dval_count = 0;
      busy_count = 0;
   endtask

   // ========================================
   // line driver
   // ========================================

   // one manchester word with optionally flipped parity
   task automatic send_word(input logic [15:0] data,
                            input mil1553_pkg::word_kind_e kind,
                            input logic bad_parity);
      logic [HALF_BITS-1:0] levels;
      logic                 par;
      int                   h;
      int                   c;
      par = ~(^data) ^ bad_parity;
      // sync goes high first for command words
      if (kind == mil1553_pkg::KIND_COMMAND) begin
         levels[HALF_BITS-1 -: 6] = 6'b111000;
      end else begin
         levels[HALF_BITS-1 -: 6] = 6'b000111;
      end
      // one is high-then-low and msb goes first
      for (h = 0; h < 16; h++) begin
         levels[HALF_BITS-7-2*h] = data[15-h];
         levels[HALF_BITS-8-2*h] = ~data[15-h];
      end
      levels[1] = par;
      levels[0] = ~par;
      for (h = HALF_BITS - 1; h >= 0; h--) begin
         for (c = 0; c < `HALF_BIT; c++) begin
            @(posedge enc_clk);
            rx_p <= levels[h];
            rx_n <= ~levels[h];
         end
      end
   endtask

   task automatic drive_idle(input int cycles);
      repeat (cycles) begin
         @(posedge enc_clk);
         rx_p <= 1'b0;
         rx_n <= 1'b0;
      end
   endtask

   // ========================================
   // waits
   // ========================================

   task automatic wait_rx_words(input int n);
      int waited;
      waited = 0;
      while (!timed_out && (csw_count + dw_count + perr_count < n)) begin
         if (waited >= WAIT_LIMIT) begin
            report_timeout($sformatf("%0d decoded rx words", n));
         end else begin
            @(posedge enc_clk);
            waited++;
         end
      end
   endtask

   task automatic wait_tx_idle();
      int waited;
      waited = 0;
      while (!timed_out && (tx_busy || mon_active)) begin
         if (waited >= WAIT_LIMIT) begin
            report_timeout("the encoder to go idle");
         end else begin
            @(posedge enc_clk);
            waited++;
         end
      end
   endtask

   // filter and encoder start add two cycles before tx_busy rises
   task automatic drain_pipeline(input int n_rx);
      wait_rx_words(n_rx);
      repeat (4) @(posedge enc_clk);
      wait_tx_idle();
   endtask

   task automatic compare_forwarded(input string test);
      int i;
      assert (got_words.size() == exp_words.size()) else
         log_error($sformatf("%s: %0d words forwarded, expected %0d",
                             test, got_words.size(), exp_words.size()));
      for (i = 0; i < exp_words.size() && i < got_words.size(); i++) begin
         assert (got_words[i] == exp_words[i] && got_kinds[i] == exp_kinds[i]) else
            log_error($sformatf("%s: word %0d is %h kind %0d, expected %h kind %0d",
                                test, i, got_words[i], got_kinds[i],
                                exp_words[i], exp_kinds[i]));
      end
   endtask

   // ========================================
   // tx line monitor
   // ========================================

   // rebuild word and kind from the sampled half-bits
   task automatic decode_frame();
      logic [15:0] w;
      logic        par;
      logic        shape_ok;
      int          i;
      shape_ok = 1'b1;
      for (i = 0; i < 3; i++) begin
         if (halves[i] != halves[0] || halves[i+3] == halves[0]) shape_ok = 1'b0;
      end
      // every data and parity bit needs its mid-bit transition
      for (i = 0; i < 17; i++) begin
         if (halves[6+2*i] == halves[7+2*i]) shape_ok = 1'b0;
      end
      for (i = 0; i < 16; i++) begin
         w[15-i] = halves[6+2*i];
      end
      par = halves[38];
      assert (shape_ok) else log_error($sformatf("tx word %h is not valid manchester", w));
      assert (^{w, par}) else log_error($sformatf("tx word %h has even parity", w));
      got_words.push_back(w);
      got_kinds.push_back(halves[0] ? mil1553_pkg::KIND_COMMAND : mil1553_pkg::KIND_DATA);
   endtask

   // sampled on the falling edge between DUT updates
   always @(negedge enc_clk) begin : line_monitor
      logic word_start;
      if (reset_slow) begin
         mon_active = 1'b0;
         mon_cyc    = 0;
         busy_q     = 1'b0;
         dval_q     = 1'b0;
      end else begin
         // new word on a busy rise or straight after a dval
         word_start = tx_busy && (!busy_q || dval_q);
         if (!bypass) begin
            assert (tx_busy || (!tx_p && !tx_n)) else
               log_error("tx pair not low while encoder idle");
            assert (!tx_busy || (tx_n != tx_p)) else
               log_error("tx_n is not the complement of tx_p");
         end
         if (word_start) begin
            mon_active = 1'b1;
            mon_cyc    = 0;
         end else begin
            assert (!tx_busy || mon_active) else
               log_error("tx_busy held past the end of a word");
         end
         if (mon_active) begin
            // middle of each half-bit
            if (mon_cyc % `HALF_BIT == `HALF_BIT / 2) begin
               halves[mon_cyc / `HALF_BIT] = tx_p;
            end
            assert (tx_busy) else
               log_error($sformatf("tx_busy dropped after %0d cycles", mon_cyc));
            if (mon_cyc == WORD_CLKS - 1) begin
               assert (tx_dval) else log_error("tx_dval missing on cycle 160 of a word");
               decode_frame();
               mon_active = 1'b0;
            end else begin
               assert (!tx_dval) else
                  log_error($sformatf("tx_dval early, on cycle %0d of a word", mon_cyc + 1));
            end
            mon_cyc++;
         end
         if (tx_dval) dval_count++;
         if (tx_busy) busy_count++;
         if (csw) csw_count++;
         if (dw) dw_count++;
         if (perr) perr_count++;
         // bypass is two synchronizer flops deep
         if (bypass_chk) begin
            assert (tx_p == rx_p_d2 && tx_n == rx_n_d2) else
               log_error($sformatf("bypass tx %b%b, rx two cycles back %b%b",
                                   tx_p, tx_n, rx_p_d2, rx_n_d2));
         end
         busy_q = tx_busy;
         dval_q = tx_dval;
      end
      rx_p_d2 = rx_p_d1;
      rx_n_d2 = rx_n_d1;
      rx_p_d1 = rx_p;
      rx_n_d1 = rx_n;
   end

   // ========================================
   // tests
   // ========================================

   task automatic check_reset_state();
      int waited;
      int i;
      waited = 0;
      @(negedge enc_clk);
      while (reset_slow && !timed_out) begin
         assert (outputs_low()) else log_error("outputs not low during reset");
         if (waited >= WAIT_LIMIT) begin
            report_timeout("reset release");
         end else begin
            @(negedge enc_clk);
            waited++;
         end
      end
      // nothing may move on an idle line
      for (i = 0; i < 8; i++) begin
         assert (outputs_low()) else log_error("outputs not low after reset");
         @(negedge enc_clk);
      end
   endtask

   task automatic forward_matching_message();
      logic [15:0] cmd;
      logic [15:0] data;
      int          i;
      clear_counts();
      cmd = command_word(`FILTER_RT, `FILTER_SUB, 5'd3);
      send_word(cmd, mil1553_pkg::KIND_COMMAND, 1'b0);
      expect_word(cmd, mil1553_pkg::KIND_COMMAND);
      for (i = 0; i < 3; i++) begin
         data = 16'($urandom());
         send_word(data, mil1553_pkg::KIND_DATA, 1'b0);
         expect_word(data, mil1553_pkg::KIND_DATA);
      end
      drive_idle(IDLE_GAP);
      drain_pipeline(4);
      compare_forwarded("matching message");
      assert (dval_count == 4) else log_error($sformatf("%0d tx_dval pulses", dval_count));
      assert (busy_count == 4 * WORD_CLKS) else
         log_error($sformatf("tx_busy high for %0d cycles", busy_count));
   endtask

   task automatic block_foreign_messages();
      int i;
      clear_counts();
      // wrong rt and then wrong subaddress
      send_word(command_word(`FILTER_RT ^ 5'h01, `FILTER_SUB, 5'd2),
                mil1553_pkg::KIND_COMMAND, 1'b0);
      for (i = 0; i < 2; i++) begin
         send_word(16'($urandom()), mil1553_pkg::KIND_DATA, 1'b0);
      end
      send_word(command_word(`FILTER_RT, `FILTER_SUB ^ 5'h03, 5'd1),
                mil1553_pkg::KIND_COMMAND, 1'b0);
      send_word(16'($urandom()), mil1553_pkg::KIND_DATA, 1'b0);
      drive_idle(IDLE_GAP);
      drain_pipeline(5);
      compare_forwarded("foreign messages");
      assert (dval_count == 0 && busy_count == 0) else
         log_error($sformatf("blocked words sent, %0d dval pulses", dval_count));
      assert (csw_count == 2 && dw_count == 3) else
         log_error($sformatf("csw %0d dw %0d, expected 2 and 3", csw_count, dw_count));
   endtask

   task automatic truncate_at_count();
      logic [15:0] cmd;
      logic [15:0] data;
      int          i;
      clear_counts();
      cmd = command_word(`FILTER_RT, `FILTER_SUB, 5'd2);
      send_word(cmd, mil1553_pkg::KIND_COMMAND, 1'b0);
      expect_word(cmd, mil1553_pkg::KIND_COMMAND);
      // only the first two data words are owed
      for (i = 0; i < 4; i++) begin
         data = 16'($urandom());
         send_word(data, mil1553_pkg::KIND_DATA, 1'b0);
         if (i < 2) expect_word(data, mil1553_pkg::KIND_DATA);
      end
      drive_idle(IDLE_GAP);
      drain_pipeline(5);
      compare_forwarded("count of two");
      assert (dval_count == 3) else log_error($sformatf("%0d tx_dval pulses", dval_count));
   endtask

   task automatic skip_bad_parity();
      logic [15:0] cmd;
      logic [15:0] data;
      int          i;
      clear_counts();
      cmd = command_word(`FILTER_RT, `FILTER_SUB, 5'd2);
      send_word(cmd, mil1553_pkg::KIND_COMMAND, 1'b0);
      expect_word(cmd, mil1553_pkg::KIND_COMMAND);
      // second data word is corrupt and must not use up the count
      for (i = 0; i < 4; i++) begin
         data = 16'($urandom());
         send_word(data, mil1553_pkg::KIND_DATA, i == 1);
         if (i == 0 || i == 2) expect_word(data, mil1553_pkg::KIND_DATA);
      end
      drive_idle(IDLE_GAP);
      drain_pipeline(5);
      compare_forwarded("bad parity");
      assert (perr_count == 1 && dw_count == 3) else
         log_error($sformatf("perr %0d dw %0d, expected 1 and 3", perr_count, dw_count));
   endtask

   task automatic bypass_passthrough();
      clear_counts();
      @(posedge enc_clk);
      bypass <= 1'b1;
      repeat (3) @(posedge enc_clk);
      bypass_chk = 1'b1;
      // a foreign command keeps the encoder out of it
      send_word(command_word(`FILTER_RT ^ 5'h04, `FILTER_SUB, 5'd1),
                mil1553_pkg::KIND_COMMAND, 1'b0);
      drive_idle(IDLE_GAP);
      bypass_chk = 1'b0;
      drain_pipeline(1);
      @(posedge enc_clk);
      bypass <= 1'b0;
      assert (csw_count == 1 && busy_count == 0) else
         log_error($sformatf("bypass word: csw %0d busy %0d", csw_count, busy_count));
   endtask

   // ========================================
   // main sequence
   // ========================================

   initial begin
      rx_p          = 1'b0;
      rx_n          = 1'b0;
      bypass        = 1'b0;
      bypass_chk    = 1'b0;
      error_count   = 0;
      timeout_count = 0;
      timed_out     = 1'b0;
      rx_p_d1       = 1'b0;
      rx_p_d2       = 1'b0;
      rx_n_d1       = 1'b0;
      rx_n_d2       = 1'b0;
      mon_active    = 1'b0;
      clear_counts();
      void'($urandom(32'hdc9ebb16));

      check_reset_state();
      if (!timed_out) forward_matching_message();
      if (!timed_out) block_foreign_messages();
      if (!timed_out) truncate_at_count();
      if (!timed_out) skip_bad_parity();
      if (!timed_out) bypass_passthrough();

      $display("Checks complete: %0d errors, %0d timeouts", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`default_nettype none

// free running enc_clk plus a power-on reset
module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 16
) (
   output logic enc_clk,
   output logic reset_slow
);
   timeunit 1ns;
   timeprecision 100ps;

   // clock starts low, first rising edge at half a period
   initial begin
      enc_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2);
         enc_clk = ~enc_clk;
      end
   end

   // reset high from time zero, released on a rising edge
   initial begin
      reset_slow = 1'b1;
      repeat (RESET_CYCLES) @(posedge enc_clk);
      reset_slow <= 1'b0;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
rtl/mil1553_pkg.sv
rtl/word_if.sv
rtl/manchester_decoder.sv
rtl/command_filter.sv
rtl/manchester_encoder.sv
rtl/bus_filter_top.sv
sim/tb_clock_gen.sv
sim/tb_bus_filter.sv
